/* design/enet_pkg.sv */
package enet_pkg;

    // byte offsets of the registers within the MAC block
    typedef enum logic [11:0] {
        EIR  = 12'h004,
        EIMR = 12'h008,
        ECR  = 12'h024,
        PALR = 12'h0E4,
        PAUR = 12'h0E8
    } reg_addr_e;

    // ECR control bits
    localparam int ECR_RESET_BIT    = 0;
    localparam int ECR_EN_BIT       = 1;
    localparam int ECR_RMII_SEL_BIT = 2;
    localparam int ECR_MII_SEL_BIT  = 3;
    localparam int ECR_RMII10T_BIT  = 4;

    // max frame length field of ECR
    localparam int ECR_MAXFL_LSB = 16;
    localparam int ECR_MAXFL_W   = 14;

    // pause frame type returned in the low half of PAUR
    localparam logic [15:0] PAUR_TYPE = 16'h8808;

endpackage

/* design/enet_apb_slave.sv */
module enet_apb_slave #(
    parameter int ADDR_W     = 12,
    parameter int NUM_EVENTS = 8
) (
    input  logic              clk,
    input  logic              enet_rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [31:0]       pwdata,
    input  logic [31:0]       ecr,
    input  logic [31:0]       eir,
    input  logic [31:0]       eimr,
    input  logic [31:0]       palr,
    input  logic [31:0]       paur,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              ecr_wen,
    output logic              eir_wen,
    output logic              eimr_wen,
    output logic              palr_wen,
    output logic              paur_wen,
    output logic              write_success,
    output logic [31:0]       reg_wdata
);

    // only the implemented event bits are visible in EIR and EIMR
    localparam logic [31:0] EVT_MASK = (NUM_EVENTS >= 32) ? 32'hffff_ffff :
                                       ((32'h1 << NUM_EVENTS) - 32'h1);

    logic setup_q;
    logic access;
    logic mapped;
    logic misaligned;
    logic addr_ok;
    logic sel_ecr;
    logic sel_eir;
    logic sel_eimr;
    logic sel_palr;
    logic sel_paur;

    // an access phase is accepted only right after a setup phase
    always_ff @(posedge clk or negedge enet_rst_n) begin
        if (!enet_rst_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel & ~penable;
        end
    end

    assign access = psel & penable & setup_q;

    assign sel_ecr  = (paddr == ADDR_W'(enet_pkg::ECR));
    assign sel_eir  = (paddr == ADDR_W'(enet_pkg::EIR));
    assign sel_eimr = (paddr == ADDR_W'(enet_pkg::EIMR));
    assign sel_palr = (paddr == ADDR_W'(enet_pkg::PALR));
    assign sel_paur = (paddr == ADDR_W'(enet_pkg::PAUR));

    assign mapped     = sel_ecr | sel_eir | sel_eimr | sel_palr | sel_paur;
    assign misaligned = |paddr[1:0];
    assign addr_ok    = mapped & ~misaligned;

    assign pready        = 1'b1; // zero wait states
    assign pslverr       = access & ~addr_ok;
    assign write_success = access & pwrite & addr_ok;

    assign ecr_wen   = sel_ecr;
    assign eir_wen   = sel_eir;
    assign eimr_wen  = sel_eimr;
    assign palr_wen  = sel_palr;
    assign paur_wen  = sel_paur;
    assign reg_wdata = pwdata;

    always_comb begin
        prdata = '0;
        if (access & ~pwrite & addr_ok) begin
            case (paddr)
                ADDR_W'(enet_pkg::ECR):  prdata = ecr;
                ADDR_W'(enet_pkg::EIR):  prdata = eir & EVT_MASK;
                ADDR_W'(enet_pkg::EIMR): prdata = eimr & EVT_MASK;
                ADDR_W'(enet_pkg::PALR): prdata = palr;
                ADDR_W'(enet_pkg::PAUR): prdata = paur;
                default:                 prdata = '0;
            endcase
        end
    end

endmodule

/* design/enet_ecr.sv */
module enet_ecr (
    input  logic        clk,
    input  logic        enet_rst_n,
    input  logic        ecr_wen,
    input  logic        write_success,
    input  logic [31:0] reg_wdata,
    output logic        rst_n,
    output logic [31:0] ecr,
    output logic        ether_en,
    output logic        mii_select,
    output logic        rmii_select,
    output logic        rmii_10T,
    output logic [13:0] max_fl
);

    logic [1:0] rst_sync;
    logic       ecr_write;
    logic       soft_rst_req;

    assign ecr_write    = ecr_wen & write_success;
    assign soft_rst_req = ecr_write & ~reg_wdata[enet_pkg::ECR_RESET_BIT];

    // soft reset holds the block in reset for two cycles after the last request
    always_ff @(posedge clk or negedge enet_rst_n) begin
        if (!enet_rst_n) begin
            rst_sync <= 2'b00;
        end else if (soft_rst_req) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_n = rst_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ether_en    <= 1'b0;
            rmii_select <= 1'b0;
            mii_select  <= 1'b0;
            rmii_10T    <= 1'b0;
            max_fl      <= '0;
        end else if (ecr_write) begin
            ether_en    <= reg_wdata[enet_pkg::ECR_EN_BIT];
            rmii_select <= reg_wdata[enet_pkg::ECR_RMII_SEL_BIT];
            mii_select  <= reg_wdata[enet_pkg::ECR_MII_SEL_BIT];
            rmii_10T    <= reg_wdata[enet_pkg::ECR_RMII10T_BIT];
            max_fl      <= reg_wdata[enet_pkg::ECR_MAXFL_LSB +: enet_pkg::ECR_MAXFL_W];
        end
    end

    // the reset bit is write-only and reads back as zero
    always_comb begin
        ecr                                                    = '0;
        ecr[enet_pkg::ECR_EN_BIT]                              = ether_en;
        ecr[enet_pkg::ECR_RMII_SEL_BIT]                        = rmii_select;
        ecr[enet_pkg::ECR_MII_SEL_BIT]                         = mii_select;
        ecr[enet_pkg::ECR_RMII10T_BIT]                         = rmii_10T;
        ecr[enet_pkg::ECR_MAXFL_LSB +: enet_pkg::ECR_MAXFL_W]  = max_fl;
    end

endmodule

/* design/enet_mac_addr.sv */
module enet_mac_addr (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        palr_wen,
    input  logic        paur_wen,
    input  logic        write_success,
    input  logic [31:0] reg_wdata,
    output logic [31:0] palr,
    output logic [31:0] paur,
    output logic [47:0] mac_addr
);

    logic [31:0] palr_q; // station address bytes 0 to 3
    logic [15:0] paur_q; // station address bytes 4 and 5

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            palr_q <= '0;
        end else if (palr_wen & write_success) begin
            palr_q <= reg_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paur_q <= '0;
        end else if (paur_wen & write_success) begin
            paur_q <= reg_wdata[31:16];
        end
    end

    assign palr = palr_q;
    assign paur = {paur_q, enet_pkg::PAUR_TYPE}; // type field is read-only

    // byte 0 sits in the top of PALR and leads the address
    assign mac_addr = {palr_q, paur_q};

endmodule

/* design/enet_irq.sv */
module enet_irq #(
    parameter int NUM_EVENTS = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  eir_wen,
    input  logic                  eimr_wen,
    input  logic                  write_success,
    input  logic [31:0]           reg_wdata,
    input  logic [NUM_EVENTS-1:0] events,
    output logic [31:0]           eir,
    output logic [31:0]           eimr,
    output logic                  irq
);

    logic [NUM_EVENTS-1:0] eir_q;
    logic [NUM_EVENTS-1:0] eimr_q;
    logic [NUM_EVENTS-1:0] eir_clr;

    // write one to clear acts only on the bits that exist
    assign eir_clr = (eir_wen & write_success) ? reg_wdata[NUM_EVENTS-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eir_q <= '0;
        end else begin
            eir_q <= (eir_q & ~eir_clr) | events; // a fresh event beats the clear
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eimr_q <= '0;
        end else if (eimr_wen & write_success) begin
            eimr_q <= reg_wdata[NUM_EVENTS-1:0];
        end
    end

    // unimplemented upper bits read as zero
    assign eir  = 32'(eir_q);
    assign eimr = 32'(eimr_q);

    assign irq = |(eir_q & eimr_q);

endmodule

/* design/enet_regs.sv */
module enet_regs #(
    parameter int ADDR_W     = 12,
    parameter int NUM_EVENTS = 8
) (
    input  logic                  clk,
    input  logic                  enet_rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [ADDR_W-1:0]     paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic [NUM_EVENTS-1:0] events,
    output logic                  rst_n,
    output logic                  ether_en,
    output logic                  mii_select,
    output logic                  rmii_select,
    output logic                  rmii_10T,
    output logic [13:0]           max_fl,
    output logic [47:0]           mac_addr,
    output logic                  irq
);

    logic        ecr_wen;
    logic        eir_wen;
    logic        eimr_wen;
    logic        palr_wen;
    logic        paur_wen;
    logic        write_success;
    logic [31:0] reg_wdata;
    logic [31:0] ecr;
    logic [31:0] eir;
    logic [31:0] eimr;
    logic [31:0] palr;
    logic [31:0] paur;

    // bus side stays on the hard reset so the host can always reach ECR
    enet_apb_slave #(
        .ADDR_W     (ADDR_W),
        .NUM_EVENTS (NUM_EVENTS)
    ) u_apb_slave (
        .clk           (clk),
        .enet_rst_n    (enet_rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .ecr           (ecr),
        .eir           (eir),
        .eimr          (eimr),
        .palr          (palr),
        .paur          (paur),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .ecr_wen       (ecr_wen),
        .eir_wen       (eir_wen),
        .eimr_wen      (eimr_wen),
        .palr_wen      (palr_wen),
        .paur_wen      (paur_wen),
        .write_success (write_success),
        .reg_wdata     (reg_wdata)
    );

    enet_ecr u_ecr (
        .clk           (clk),
        .enet_rst_n    (enet_rst_n),
        .ecr_wen       (ecr_wen),
        .write_success (write_success),
        .reg_wdata     (reg_wdata),
        .rst_n         (rst_n),
        .ecr           (ecr),
        .ether_en      (ether_en),
        .mii_select    (mii_select),
        .rmii_select   (rmii_select),
        .rmii_10T      (rmii_10T),
        .max_fl        (max_fl)
    );

    enet_mac_addr u_mac_addr (
        .clk           (clk),
        .rst_n         (rst_n),
        .palr_wen      (palr_wen),
        .paur_wen      (paur_wen),
        .write_success (write_success),
        .reg_wdata     (reg_wdata),
        .palr          (palr),
        .paur          (paur),
        .mac_addr      (mac_addr)
    );

    enet_irq #(
        .NUM_EVENTS (NUM_EVENTS)
    ) u_irq (
        .clk           (clk),
        .rst_n         (rst_n),
        .eir_wen       (eir_wen),
        .eimr_wen      (eimr_wen),
        .write_success (write_success),
        .reg_wdata     (reg_wdata),
        .events        (events),
        .eir           (eir),
        .eimr          (eimr),
        .irq           (irq)
    );

endmodule

/* sim/enet_regs_chk.sv */
module enet_regs_chk (
    input logic        clk,
    input logic        enet_rst_n,
    input logic        psel,
    input logic        penable,
    input logic        pslverr,
    input logic        ecr_wen,
    input logic        write_success,
    input logic [31:0] reg_wdata,
    input logic        rst_n,
    input logic [31:0] eir,
    input logic [31:0] eimr,
    input logic        irq
);

    int unsigned fail_count = 0;

    a_pslverr_access: assert property (
        @(posedge clk) disable iff (!enet_rst_n) pslverr |-> (psel && penable)
    ) else begin
        fail_count++;
        $error("pslverr high outside an APB access cycle");
    end

    // a soft reset request pulls rst_n low on the following cycle
    a_soft_reset: assert property (
        @(posedge clk) disable iff (!enet_rst_n)
        (write_success && ecr_wen && !reg_wdata[enet_pkg::ECR_RESET_BIT]) |=> !rst_n
    ) else begin
        fail_count++;
        $error("rst_n did not fall after an ECR write with bit 0 clear");
    end

    a_irq_source: assert property (
        @(posedge clk) disable iff (!enet_rst_n) irq |-> |(eir & eimr)
    ) else begin
        fail_count++;
        $error("irq high without a set and unmasked EIR bit");
    end

endmodule

bind enet_regs enet_regs_chk u_chk (
    .clk           (clk),
    .enet_rst_n    (enet_rst_n),
    .psel          (psel),
    .penable       (penable),
    .pslverr       (pslverr),
    .ecr_wen       (ecr_wen),
    .write_success (write_success),
    .reg_wdata     (reg_wdata),
    .rst_n         (rst_n),
    .eir           (eir),
    .eimr          (eimr),
    .irq           (irq)
);

/* sim/enet_regs_tb.sv */
module enet_regs_tb;

    localparam int ADDR_W     = 12;
    localparam int NUM_EVENTS = 8;
    localparam int TIMEOUT    = 40;

    // only these ECR bits hold state and the rest read as zero
    localparam logic [31:0] ECR_MASK =
        (32'h1 << enet_pkg::ECR_EN_BIT) | (32'h1 << enet_pkg::ECR_RMII_SEL_BIT) |
        (32'h1 << enet_pkg::ECR_MII_SEL_BIT) | (32'h1 << enet_pkg::ECR_RMII10T_BIT) |
        (((32'h1 << enet_pkg::ECR_MAXFL_W) - 32'h1) << enet_pkg::ECR_MAXFL_LSB);

    localparam logic [ADDR_W-1:0] REG_MAP [5] = '{
        enet_pkg::EIR, enet_pkg::EIMR, enet_pkg::ECR, enet_pkg::PALR, enet_pkg::PAUR
    };

    logic                  clk = 1'b0;
    logic                  enet_rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_W-1:0]     paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [NUM_EVENTS-1:0] events;
    logic                  rst_n;
    logic                  ether_en;
    logic                  mii_select;
    logic                  rmii_select;
    logic                  rmii_10T;
    logic [13:0]           max_fl;
    logic [47:0]           mac_addr;
    logic                  irq;

    // register model
    logic [31:0]           ecr_m;
    logic [NUM_EVENTS-1:0] eir_m;
    logic [NUM_EVENTS-1:0] eimr_m;
    logic [31:0]           palr_m;
    logic [15:0]           paur_m;
    string                 test_name;

    enet_regs #(
        .ADDR_W     (ADDR_W),
        .NUM_EVENTS (NUM_EVENTS)
    ) uut (
        .clk         (clk),
        .enet_rst_n  (enet_rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .events      (events),
        .rst_n       (rst_n),
        .ether_en    (ether_en),
        .mii_select  (mii_select),
        .rmii_select (rmii_select),
        .rmii_10T    (rmii_10T),
        .max_fl      (max_fl),
        .mac_addr    (mac_addr),
        .irq         (irq)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (uut.u_chk.fail_count != 0) begin
            $display("the bound checker reported an assertion failure");
            $display("Simulation failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error [%s] %s expected %h actual %h", test_name, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one APB transfer whose event pulse lands on the access edge
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic [NUM_EVENTS-1:0] ev,
                            output logic [31:0] rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        events  <= ev;
        @(negedge clk);
        while (pready !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                $display("the APB slave never answered at address %h", addr);
                $display("Simulation failed");
                $fatal(1, "APB timeout");
            end
            cycles++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        events  <= '0;
    endtask

    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, wdata, '0, rdata, err);
        check("pslverr on write", 1'b0, err);
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, '0, rdata, err);
        check("pslverr on read", 1'b0, err);
    endtask

    task automatic pulse_events(input logic [NUM_EVENTS-1:0] ev);
        @(posedge clk);
        events <= ev;
        @(posedge clk);
        events <= '0;
        eir_m = eir_m | ev;
    endtask

    task automatic model_reset();
        ecr_m  = '0;
        eir_m  = '0;
        eimr_m = '0;
        palr_m = '0;
        paur_m = '0;
    endtask

    // sample at a falling edge where every output has settled
    task automatic check_outputs();
        check("ether_en", ecr_m[enet_pkg::ECR_EN_BIT], ether_en);
        check("mii_select", ecr_m[enet_pkg::ECR_MII_SEL_BIT], mii_select);
        check("rmii_select", ecr_m[enet_pkg::ECR_RMII_SEL_BIT], rmii_select);
        check("rmii_10T", ecr_m[enet_pkg::ECR_RMII10T_BIT], rmii_10T);
        check("max_fl", ecr_m[enet_pkg::ECR_MAXFL_LSB +: enet_pkg::ECR_MAXFL_W], max_fl);
        check("mac_addr", {palr_m, paur_m}, mac_addr);
        check("irq", |(eir_m & eimr_m), irq);
    endtask

    task automatic readback_all();
        logic [31:0] rdata;
        reg_read(enet_pkg::ECR, rdata);
        check("ECR readback", ecr_m, rdata);
        reg_read(enet_pkg::EIR, rdata);
        check("EIR readback", eir_m, rdata);
        reg_read(enet_pkg::EIMR, rdata);
        check("EIMR readback", eimr_m, rdata);
        reg_read(enet_pkg::PALR, rdata);
        check("PALR readback", palr_m, rdata);
        reg_read(enet_pkg::PAUR, rdata);
        check("PAUR readback", {paur_m, enet_pkg::PAUR_TYPE}, rdata);
    endtask

    // rst_n must be low for exactly two samples before it rises
    task automatic wait_rst_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        check("rst_n asserted", 1'b0, rst_n);
        while (rst_n !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                $display("rst_n was never released after the reset request");
                $display("Simulation failed");
                $fatal(1, "reset timeout");
            end
            cycles++;
            @(negedge clk);
        end
        check("rst_n low cycles", 2, cycles);
    endtask

    task automatic load_random();
        logic [31:0] wdata;
        wdata = $urandom | 32'h1;
        reg_write(enet_pkg::ECR, wdata);
        ecr_m = wdata & ECR_MASK;
        palr_m = $urandom;
        reg_write(enet_pkg::PALR, palr_m);
        wdata = $urandom;
        reg_write(enet_pkg::PAUR, wdata);
        paur_m = wdata[31:16];
        wdata = $urandom;
        reg_write(enet_pkg::EIMR, wdata);
        eimr_m = wdata[NUM_EVENTS-1:0];
        pulse_events(NUM_EVENTS'($urandom));
    endtask

    function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
        foreach (REG_MAP[i]) begin
            if (addr == REG_MAP[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // either a register offset knocked off its word boundary or a hole in the map
    function automatic logic [ADDR_W-1:0] pick_bad_addr();
        logic [ADDR_W-1:0] addr;
        if ($urandom_range(1) == 1) begin
            addr = REG_MAP[$urandom_range(4)] + ADDR_W'($urandom_range(3, 1));
        end else begin
            addr = ADDR_W'($urandom);
            while (is_mapped(addr)) begin
                addr = ADDR_W'($urandom);
            end
        end
        return addr;
    endfunction

    initial begin
        logic [31:0]           rdata;
        logic [31:0]           wdata;
        logic [NUM_EVENTS-1:0] ev;
        logic                  wr;
        logic                  err;
        void'($urandom(51411));
        enet_rst_n = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        events     = '0;
        model_reset();

        test_name = "reset values";
        repeat (8) @(posedge clk);
        enet_rst_n <= 1'b1;
        wait_rst_release();
        check("pready", 1'b1, pready);
        check("pslverr", 1'b0, pslverr);
        check_outputs();
        readback_all();

        test_name = "ecr fields";
        repeat (20) begin
            wdata = $urandom | 32'h1; // keep the soft reset bit set
            reg_write(enet_pkg::ECR, wdata);
            ecr_m = wdata & ECR_MASK;
            @(negedge clk);
            check_outputs();
            reg_read(enet_pkg::ECR, rdata);
            check("ECR readback", ecr_m, rdata);
        end

        test_name = "station address";
        repeat (20) begin
            wdata = $urandom;
            if ($urandom_range(1) == 1) begin
                reg_write(enet_pkg::PALR, wdata);
                palr_m = wdata;
            end else begin
                reg_write(enet_pkg::PAUR, wdata);
                paur_m = wdata[31:16];
            end
            @(negedge clk);
            check_outputs();
            reg_read(enet_pkg::PALR, rdata);
            check("PALR readback", palr_m, rdata);
            reg_read(enet_pkg::PAUR, rdata);
            check("PAUR readback", {paur_m, enet_pkg::PAUR_TYPE}, rdata);
        end

        test_name = "interrupts";
        repeat (40) begin
            ev    = NUM_EVENTS'($urandom);
            wdata = $urandom;
            case ($urandom_range(2))
                0: pulse_events(ev);
                1: begin
                    reg_write(enet_pkg::EIMR, wdata);
                    eimr_m = wdata[NUM_EVENTS-1:0];
                end
                default: begin
                    apb_xfer(1'b1, enet_pkg::EIR, wdata, ev, rdata, err);
                    check("pslverr on EIR clear", 1'b0, err);
                    eir_m = (eir_m & ~wdata[NUM_EVENTS-1:0]) | ev;
                end
            endcase
            @(negedge clk);
            check_outputs();
            reg_read(enet_pkg::EIR, rdata);
            check("EIR readback", eir_m, rdata);
        end

        test_name = "soft reset";
        load_random();
        reg_write(enet_pkg::ECR, $urandom & ~32'h1);
        model_reset();
        wait_rst_release();
        check_outputs();
        readback_all();

        test_name = "address errors";
        load_random();
        repeat (30) begin
            wr = $urandom_range(1);
            apb_xfer(wr, pick_bad_addr(), $urandom, '0, rdata, err);
            check("pslverr", 1'b1, err);
            if (!wr) begin
                check("errored read data", 32'h0, rdata);
            end
        end
        @(negedge clk);
        check_outputs();
        readback_all();

        if (uut.u_chk.fail_count != 0) begin
            $display("the bound checker reported %0d assertion failures", uut.u_chk.fail_count);
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
design/enet_pkg.sv
design/enet_apb_slave.sv
design/enet_ecr.sv
design/enet_mac_addr.sv
design/enet_irq.sv
design/enet_regs.sv
sim/enet_regs_chk.sv
sim/enet_regs_tb.sv

/* Bender.yml */
package:
  name: enet_regs

sources:
  - files:
      - design/enet_pkg.sv
      - design/enet_apb_slave.sv
      - design/enet_ecr.sv
      - design/enet_mac_addr.sv
      - design/enet_irq.sv
      - design/enet_regs.sv
  - target: simulation
    files:
      - sim/enet_regs_chk.sv
      - sim/enet_regs_tb.sv
